//--- design/pmu_pkg.sv
// PMU package with widths, address map, opcodes, event codes and port structs
package pmu_pkg;

  localparam int CNT_W      = 64;
  localparam int AXI_DATA_W = 32;
  localparam int AXI_ADDR_W = 12;
  localparam int NUM_HPM    = 4;
  localparam int NUM_CNT    = NUM_HPM + 2;
  localparam int CNT_IDX_W  = 3;
  localparam int INH_W      = NUM_CNT + 1;

  // Inhibit layout as in mcountinhibit
  localparam int INH_CY_BIT   = 0;
  localparam int INH_IR_BIT   = 2;
  localparam int INH_HPM_BASE = 3;

  localparam logic [AXI_ADDR_W-1:0] ADDR_INHIBIT    = 12'h000;
  localparam logic [AXI_ADDR_W-1:0] ADDR_EVSEL_BASE = 12'h010;
  localparam logic [AXI_ADDR_W-1:0] ADDR_EVSEL_END  = ADDR_EVSEL_BASE + AXI_ADDR_W'(4 * NUM_HPM);
  localparam logic [AXI_ADDR_W-1:0] ADDR_CNT_BASE   = 12'h100;
  localparam logic [AXI_ADDR_W-1:0] ADDR_CNT_END    = ADDR_CNT_BASE + AXI_ADDR_W'(8 * NUM_CNT);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  localparam logic [6:0] OPC_ALU     = 7'b0110011;
  localparam logic [6:0] OPC_ALU_I   = 7'b0010011;
  localparam logic [6:0] OPC_ALU_W   = 7'b0111011;
  localparam logic [6:0] OPC_ALU_I_W = 7'b0011011;
  localparam logic [6:0] OPC_FP      = 7'b1010011;
  localparam logic [6:0] OPC_FMADD   = 7'b1000011;
  localparam logic [6:0] OPC_FMSUB   = 7'b1000111;
  localparam logic [6:0] OPC_FNMSUB  = 7'b1001011;
  localparam logic [6:0] OPC_FNMADD  = 7'b1001111;
  localparam logic [6:0] OPC_VECTOR  = 7'h57;
  localparam logic [2:0] F3_OPCFG    = 3'd7;
  localparam logic [1:0] FMT_S       = 2'b00;
  localparam logic [1:0] FMT_D       = 2'b01;

  localparam logic [2:0] VSEW_8  = 3'b000;
  localparam logic [2:0] VSEW_16 = 3'b001;
  localparam logic [2:0] VSEW_32 = 3'b010;
  localparam logic [2:0] VSEW_64 = 3'b011;

  // Gaps in the numbering are events this PMU does not implement
  typedef enum logic [7:0] {
    EV_NONE         = 8'd0,
    EV_NEW_INST     = 8'd1,
    EV_BRANCH       = 8'd2,
    EV_BRANCH_TAKEN = 8'd5,
    EV_SC_WORD      = 8'd6,
    EV_SC_DWORD     = 8'd7,
    EV_VEC_BYTE     = 8'd12,
    EV_VEC_HWORD    = 8'd13,
    EV_VEC_WORD     = 8'd14,
    EV_VEC_DWORD    = 8'd15
  } hpm_event_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_int_t;

  typedef struct packed {
    logic [4:0] rs3;
    logic [1:0] fmt;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] rm;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_fp_t;

  typedef union packed {
    instr_int_t i;
    instr_fp_t  f;
  } instr_u;

  typedef struct packed {
    logic       valid;
    logic       exception;
    instr_u     instr;
    logic       is_branch;
    logic       branch_taken;
    logic [2:0] vsew;
  } commit_t;

  typedef struct packed {
    logic retire;
    logic branch;
    logic taken;
    logic sc_word;
    logic sc_dword;
    logic vec_byte;
    logic vec_hword;
    logic vec_word;
    logic vec_dword;
  } event_vec_t;

  typedef struct packed {
    logic                  valid;
    logic [CNT_IDX_W-1:0]  index;
    logic                  hi;
    logic [AXI_DATA_W-1:0] data;
  } cnt_wr_t;

  typedef logic [NUM_CNT-1:0][CNT_W-1:0] cnt_array_t;
  typedef hpm_event_e [NUM_HPM-1:0] evsel_array_t;

endpackage

//--- design/pmu_event_decode.sv
// Commit classifier producing a registered PMU event vector
`timescale 1ns/100ps

module pmu_event_decode import pmu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  commit_t    commit,
  output event_vec_t events
);

  logic       retire;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [1:0] fmt;
  logic       is_fp;
  logic       is_sc_word;
  logic       is_sc_dword;
  logic       is_vec;
  event_vec_t ev_d;

  assign retire = commit.valid && !commit.exception;

  // Same word read through the integer and the FP layout
  assign opcode = commit.instr.i.opcode;
  assign funct3 = commit.instr.i.funct3;
  assign fmt    = commit.instr.f.fmt;

  assign is_fp = opcode inside {OPC_FP, OPC_FMADD, OPC_FMSUB, OPC_FNMSUB, OPC_FNMADD};

  assign is_sc_word  = (opcode inside {OPC_ALU_W, OPC_ALU_I_W}) || (is_fp && fmt == FMT_S);
  assign is_sc_dword = (opcode inside {OPC_ALU, OPC_ALU_I}) || (is_fp && fmt == FMT_D);

  // vsetvl family is configuration, not arithmetic
  assign is_vec = (opcode == OPC_VECTOR) && (funct3 != F3_OPCFG);

  always_comb begin
    ev_d           = '0;
    ev_d.retire    = retire;
    ev_d.branch    = retire && commit.is_branch;
    ev_d.taken     = retire && commit.is_branch && commit.branch_taken;
    ev_d.sc_word   = retire && is_sc_word;
    ev_d.sc_dword  = retire && is_sc_dword;
    ev_d.vec_byte  = retire && is_vec && commit.vsew == VSEW_8;
    ev_d.vec_hword = retire && is_vec && commit.vsew == VSEW_16;
    ev_d.vec_word  = retire && is_vec && commit.vsew == VSEW_32;
    ev_d.vec_dword = retire && is_vec && commit.vsew == VSEW_64;
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      events <= '0;
    end else begin
      events <= ev_d;
    end
  end

endmodule

//--- design/pmu_counter_bank.sv
// Cycle, retired and programmable 64-bit counters with inhibit and write override
`timescale 1ns/100ps

module pmu_counter_bank import pmu_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  event_vec_t       events,
  input  logic [INH_W-1:0] inhibit,
  input  evsel_array_t     evsel,
  input  cnt_wr_t          cnt_wr,
  output cnt_array_t       counters
);

  logic [NUM_CNT-1:0] run;
  logic [NUM_CNT-1:0] hit;

  // Unsupported codes never count
  function automatic logic event_bit(input hpm_event_e code, input event_vec_t ev);
    logic bit_sel;
    case (code)
      EV_NEW_INST:     bit_sel = ev.retire;
      EV_BRANCH:       bit_sel = ev.branch;
      EV_BRANCH_TAKEN: bit_sel = ev.taken;
      EV_SC_WORD:      bit_sel = ev.sc_word;
      EV_SC_DWORD:     bit_sel = ev.sc_dword;
      EV_VEC_BYTE:     bit_sel = ev.vec_byte;
      EV_VEC_HWORD:    bit_sel = ev.vec_hword;
      EV_VEC_WORD:     bit_sel = ev.vec_word;
      EV_VEC_DWORD:    bit_sel = ev.vec_dword;
      default:         bit_sel = 1'b0;
    endcase
    return bit_sel;
  endfunction

  always_comb begin
    run[0] = !inhibit[INH_CY_BIT];
    run[1] = !inhibit[INH_IR_BIT];
    // mcycle has no event qualifier
    hit[0] = 1'b1;
    hit[1] = events.retire;
    for (int h = 0; h < NUM_HPM; h++) begin
      run[2+h] = !inhibit[INH_HPM_BASE+h];
      hit[2+h] = event_bit(evsel[h], events);
    end
  end

  // Software write wins over an increment in the same cycle
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      counters <= '0;
    end else begin
      for (int i = 0; i < NUM_CNT; i++) begin
        if (cnt_wr.valid && cnt_wr.index == CNT_IDX_W'(i)) begin
          if (cnt_wr.hi) begin
            counters[i][CNT_W-1:AXI_DATA_W] <= cnt_wr.data;
          end else begin
            counters[i][AXI_DATA_W-1:0] <= cnt_wr.data;
          end
        end else if (run[i] && hit[i]) begin
          counters[i] <= counters[i] + CNT_W'(1);
        end
      end
    end
  end

endmodule

//--- design/pmu_axil_regs.sv
// AXI4-Lite register slave for inhibit, event selectors and counter access
`timescale 1ns/100ps

module pmu_axil_regs import pmu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [AXI_ADDR_W-1:0] awaddr,
  input  logic                  wvalid,
  output logic                  wready,
  input  logic [AXI_DATA_W-1:0] wdata,
  input  logic [3:0]            wstrb,
  output logic                  bvalid,
  input  logic                  bready,
  output logic [1:0]            bresp,
  input  logic                  arvalid,
  output logic                  arready,
  input  logic [AXI_ADDR_W-1:0] araddr,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [AXI_DATA_W-1:0] rdata,
  output logic [1:0]            rresp,
  input  cnt_array_t            counters,
  output logic [INH_W-1:0]      inhibit,
  output evsel_array_t          evsel,
  output cnt_wr_t               cnt_wr
);

  typedef struct packed {
    logic                 hit;
    logic                 is_inh;
    logic                 is_evsel;
    logic                 is_cnt;
    logic [CNT_IDX_W-1:0] idx;
    logic                 hi;
  } addr_dec_t;

  logic                  wr_accept;
  logic                  rd_accept;
  addr_dec_t             wr_dec;
  addr_dec_t             rd_dec;
  logic [AXI_DATA_W-1:0] rd_word;

  // Only word-aligned addresses inside a block are mapped
  function automatic addr_dec_t decode_addr(input logic [AXI_ADDR_W-1:0] addr);
    addr_dec_t             d;
    logic [AXI_ADDR_W-1:0] off_ev;
    logic [AXI_ADDR_W-1:0] off_cnt;
    d       = '0;
    off_ev  = addr - ADDR_EVSEL_BASE;
    off_cnt = addr - ADDR_CNT_BASE;
    if (addr[1:0] == 2'b00) begin
      if (addr == ADDR_INHIBIT) begin
        d.is_inh = 1'b1;
      end else if (addr >= ADDR_EVSEL_BASE && addr < ADDR_EVSEL_END) begin
        d.is_evsel = 1'b1;
        d.idx      = off_ev[4:2];
      end else if (addr >= ADDR_CNT_BASE && addr < ADDR_CNT_END) begin
        d.is_cnt = 1'b1;
        d.idx    = off_cnt[5:3];
        d.hi     = off_cnt[2];
      end
    end
    d.hit = d.is_inh || d.is_evsel || d.is_cnt;
    return d;
  endfunction

  assign wr_dec = decode_addr(awaddr);
  assign rd_dec = decode_addr(araddr);

  // AW and W are taken together
  assign wr_accept = awvalid && wvalid && !bvalid;
  assign awready   = wr_accept;
  assign wready    = wr_accept;

  assign rd_accept = arvalid && !rvalid;
  assign arready   = rd_accept;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      bvalid  <= 1'b0;
      bresp   <= RESP_OKAY;
      inhibit <= '1;
      evsel   <= '{default: EV_NONE};
      cnt_wr  <= '0;
    end else begin
      cnt_wr.valid <= 1'b0;
      if (wr_accept) begin
        bvalid <= 1'b1;
        bresp  <= wr_dec.hit ? RESP_OKAY : RESP_SLVERR;
        if (wr_dec.is_inh) begin
          inhibit <= wdata[INH_W-1:0];
        end
        if (wr_dec.is_evsel) begin
          evsel[wr_dec.idx[1:0]] <= hpm_event_e'(wdata[7:0]);
        end
        // One-cycle request, lands while bvalid is up
        if (wr_dec.is_cnt) begin
          cnt_wr.valid <= 1'b1;
          cnt_wr.index <= wr_dec.idx;
          cnt_wr.hi    <= wr_dec.hi;
          cnt_wr.data  <= wdata;
        end
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_comb begin
    rd_word = '0;
    if (rd_dec.is_inh) begin
      rd_word = AXI_DATA_W'(inhibit);
    end else if (rd_dec.is_evsel) begin
      rd_word = AXI_DATA_W'(evsel[rd_dec.idx[1:0]]);
    end else if (rd_dec.is_cnt) begin
      if (rd_dec.hi) begin
        rd_word = counters[rd_dec.idx][CNT_W-1:AXI_DATA_W];
      end else begin
        rd_word = counters[rd_dec.idx][AXI_DATA_W-1:0];
      end
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rvalid <= 1'b0;
      rresp  <= RESP_OKAY;
    end else begin
      if (rd_accept) begin
        rvalid <= 1'b1;
        rresp  <= rd_dec.hit ? RESP_OKAY : RESP_SLVERR;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Captured at acceptance, held until rready
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rdata <= rd_word;
    end
  end

endmodule

//--- design/pmu_top.sv
// PMU top level connecting event decode, counter bank and AXI4-Lite registers
`timescale 1ns/100ps

module pmu_top import pmu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  commit_t               commit,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [AXI_ADDR_W-1:0] awaddr,
  input  logic                  wvalid,
  output logic                  wready,
  input  logic [AXI_DATA_W-1:0] wdata,
  input  logic [3:0]            wstrb,
  output logic                  bvalid,
  input  logic                  bready,
  output logic [1:0]            bresp,
  input  logic                  arvalid,
  output logic                  arready,
  input  logic [AXI_ADDR_W-1:0] araddr,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [AXI_DATA_W-1:0] rdata,
  output logic [1:0]            rresp
);

  event_vec_t       events;
  logic [INH_W-1:0] inhibit;
  evsel_array_t     evsel;
  cnt_wr_t          cnt_wr;
  cnt_array_t       counters;

  pmu_event_decode u_decode (
    .clk    (clk),
    .rst    (rst),
    .commit (commit),
    .events (events)
  );

  pmu_counter_bank u_bank (
    .clk      (clk),
    .rst      (rst),
    .events   (events),
    .inhibit  (inhibit),
    .evsel    (evsel),
    .cnt_wr   (cnt_wr),
    .counters (counters)
  );

  pmu_axil_regs u_regs (
    .clk      (clk),
    .rst      (rst),
    .awvalid  (awvalid),
    .awready  (awready),
    .awaddr   (awaddr),
    .wvalid   (wvalid),
    .wready   (wready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .bvalid   (bvalid),
    .bready   (bready),
    .bresp    (bresp),
    .arvalid  (arvalid),
    .arready  (arready),
    .araddr   (araddr),
    .rvalid   (rvalid),
    .rready   (rready),
    .rdata    (rdata),
    .rresp    (rresp),
    .counters (counters),
    .inhibit  (inhibit),
    .evsel    (evsel),
    .cnt_wr   (cnt_wr)
  );

endmodule

//--- include/pmu_tb_tasks.svh
// AXI4-Lite access tasks, compare tasks and reference event rule for the PMU testbench
`ifndef PMU_TB_TASKS_SVH
`define PMU_TB_TASKS_SVH

task automatic check_data(input logic [AXI_DATA_W-1:0] got, exp, input string msg);
  if (got !== exp) begin
    $display("[FAIL] %0t: %s, got %h expected %h", $time, msg, got, exp);
    error_count++;
  end
endtask

task automatic check_resp(input logic [1:0] got, exp, input string msg);
  if (got !== exp) begin
    $display("[FAIL] %0t: %s, response %0d expected %0d", $time, msg, got, exp);
    error_count++;
  end
endtask

task automatic check_counter(input logic [CNT_W-1:0] got, exp, input string msg);
  if (got !== exp) begin
    $display("[FAIL] %0t: %s, got %0d expected %0d", $time, msg, got, exp);
    error_count++;
  end
endtask

task automatic note_timeout(input string what);
  $display("Timeout at %0t: %s", $time, what);
  timeout_count++;
endtask

task automatic axil_write(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] data,
                          input logic [1:0] exp_resp);
  int n;
  n       = 0;
  awaddr  = addr;
  wdata   = data;
  wstrb   = 4'hF;
  awvalid = 1'b1;
  wvalid  = 1'b1;
  do begin
    @(negedge clk);
    n++;
  end while (!(awready && wready) && n < WAIT_LIMIT);
  if (!(awready && wready)) note_timeout($sformatf("write to %h was never accepted", addr));
  @(posedge clk);
  #1;
  awvalid = 1'b0;
  wvalid  = 1'b0;
  bready  = 1'b1;
  n       = 0;
  do begin
    @(negedge clk);
    n++;
  end while (!bvalid && n < WAIT_LIMIT);
  if (!bvalid) note_timeout($sformatf("no write response for %h", addr));
  check_resp(bresp, exp_resp, $sformatf("write response at %h", addr));
  @(posedge clk);
  #1;
  bready = 1'b0;
endtask

task automatic axil_read(input logic [AXI_ADDR_W-1:0] addr, output logic [AXI_DATA_W-1:0] data,
                         input logic [1:0] exp_resp);
  int n;
  n       = 0;
  araddr  = addr;
  arvalid = 1'b1;
  do begin
    @(negedge clk);
    n++;
  end while (!arready && n < WAIT_LIMIT);
  if (!arready) note_timeout($sformatf("read of %h was never accepted", addr));
  @(posedge clk);
  #1;
  arvalid = 1'b0;
  rready  = 1'b1;
  n       = 0;
  do begin
    @(negedge clk);
    n++;
  end while (!rvalid && n < WAIT_LIMIT);
  if (!rvalid) note_timeout($sformatf("no read data for %h", addr));
  data = rdata;
  check_resp(rresp, exp_resp, $sformatf("read response at %h", addr));
  @(posedge clk);
  #1;
  rready = 1'b0;
endtask

// Low word first, then high word
task automatic read_counter(input int idx, output logic [CNT_W-1:0] value);
  logic [AXI_DATA_W-1:0] lo;
  logic [AXI_DATA_W-1:0] hi;
  axil_read(ADDR_CNT_BASE + AXI_ADDR_W'(8 * idx), lo, RESP_OKAY);
  axil_read(ADDR_CNT_BASE + AXI_ADDR_W'(8 * idx + 4), hi, RESP_OKAY);
  value = {hi, lo};
endtask

// Events one commit should raise
function automatic event_vec_t ref_events(input commit_t c);
  event_vec_t e;
  logic [6:0] op;
  logic       fp;
  e  = '0;
  op = c.instr.i.opcode;
  fp = (op == OPC_FP) || (op == OPC_FMADD) || (op == OPC_FMSUB) ||
       (op == OPC_FNMSUB) || (op == OPC_FNMADD);
  if (c.valid && !c.exception) begin
    e.retire   = 1'b1;
    e.branch   = c.is_branch;
    e.taken    = c.is_branch && c.branch_taken;
    e.sc_word  = (op == OPC_ALU_W) || (op == OPC_ALU_I_W) || (fp && c.instr.f.fmt == FMT_S);
    e.sc_dword = (op == OPC_ALU) || (op == OPC_ALU_I) || (fp && c.instr.f.fmt == FMT_D);
    // Widths above 64 bits shift out of the four flags
    if (op == OPC_VECTOR && c.instr.i.funct3 != F3_OPCFG) begin
      {e.vec_dword, e.vec_word, e.vec_hword, e.vec_byte} = 4'b0001 << c.vsew;
    end
  end
  return e;
endfunction

`endif

//--- tests/tb_pmu_top.sv
// Testbench for the PMU with clock, reset, random commit driver and directed tests
`timescale 1ns/100ps

module tb_pmu_top import pmu_pkg::*; ();

  localparam int                    WAIT_LIMIT = 100;
  localparam logic [AXI_DATA_W-1:0] ALL_INH    = 32'h7F;
  localparam logic [6:0]            SCALAR_OPS [8] = '{OPC_ALU, OPC_ALU_I, OPC_ALU_W,
    OPC_ALU_I_W, OPC_FP, OPC_FMADD, OPC_FNMADD, 7'b1100011};

  logic                  clk, rst;
  logic                  awvalid, awready, wvalid, wready, bvalid, bready;
  logic                  arvalid, arready, rvalid, rready;
  logic [AXI_ADDR_W-1:0] awaddr, araddr;
  logic [AXI_DATA_W-1:0] wdata, rdata;
  logic [3:0]            wstrb;
  logic [1:0]            bresp, rresp;
  commit_t               commit;
  integer                seed = 93792;
  int                    error_count = 0;
  int                    timeout_count = 0;
  int                    exp_by_code [256];

  `include "pmu_tb_tasks.svh"

  pmu_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // kind 0 random word, 1 scalar and branch mix, 2 vector
  task automatic drive_commits(input int kind, input int n);
    logic [31:0] r;
    commit_t     c;
    event_vec_t  e;
    for (int k = 0; k < n; k++) begin
      r       = $random(seed);
      c       = '0;
      c.instr = r;
      r       = $random(seed);
      c.valid        = r[2:0] != 3'd0;
      c.exception    = r[5:3] == 3'd0;
      c.is_branch    = r[6];
      c.branch_taken = r[7];
      c.vsew         = r[10:8];
      if (kind == 1) c.instr.i.opcode = SCALAR_OPS[r[14:12]];
      if (kind == 2) c.instr.i.opcode = OPC_VECTOR;
      commit = c;
      e      = ref_events(c);
      exp_by_code[EV_NEW_INST]     += int'(e.retire);
      exp_by_code[EV_BRANCH]       += int'(e.branch);
      exp_by_code[EV_BRANCH_TAKEN] += int'(e.taken);
      exp_by_code[EV_SC_WORD]      += int'(e.sc_word);
      exp_by_code[EV_SC_DWORD]     += int'(e.sc_dword);
      exp_by_code[EV_VEC_BYTE]     += int'(e.vec_byte);
      exp_by_code[EV_VEC_HWORD]    += int'(e.vec_hword);
      exp_by_code[EV_VEC_WORD]     += int'(e.vec_word);
      exp_by_code[EV_VEC_DWORD]    += int'(e.vec_dword);
      @(posedge clk);
      #1;
    end
    commit = '0;
  endtask

  task automatic register_access();
    logic [31:0] r;
    logic [31:0] d;
    axil_read(ADDR_INHIBIT, d, RESP_OKAY);
    check_data(d, ALL_INH, "inhibit after reset");
    for (int h = 0; h < NUM_HPM; h++) begin
      axil_read(ADDR_EVSEL_BASE + AXI_ADDR_W'(4 * h), d, RESP_OKAY);
      check_data(d, '0, "selector after reset");
      r = $random(seed);
      axil_write(ADDR_EVSEL_BASE + AXI_ADDR_W'(4 * h), r, RESP_OKAY);
      axil_read(ADDR_EVSEL_BASE + AXI_ADDR_W'(4 * h), d, RESP_OKAY);
      check_data(d, {24'd0, r[7:0]}, "selector readback");
    end
    axil_write(ADDR_INHIBIT, 32'h55, RESP_OKAY);
    axil_read(12'h0F0, d, RESP_SLVERR);
    check_data(d, '0, "unmapped read data");
    axil_write(12'h130, 32'hFFFF_FFFF, RESP_SLVERR);
    axil_read(ADDR_INHIBIT, d, RESP_OKAY);
    check_data(d, 32'h55, "inhibit readback");
    axil_write(ADDR_INHIBIT, ALL_INH, RESP_OKAY);
  endtask

  task automatic counter_write_inhibited();
    logic [CNT_W-1:0] vals [NUM_CNT];
    logic [CNT_W-1:0] v;
    // Every hpm counter sees an event on each retired commit
    for (int h = 0; h < NUM_HPM; h++) begin
      axil_write(ADDR_EVSEL_BASE + AXI_ADDR_W'(4 * h), AXI_DATA_W'(EV_NEW_INST), RESP_OKAY);
    end
    for (int i = 0; i < NUM_CNT; i++) begin
      vals[i] = {$random(seed), $random(seed)};
      axil_write(ADDR_CNT_BASE + AXI_ADDR_W'(8 * i), vals[i][31:0], RESP_OKAY);
      axil_write(ADDR_CNT_BASE + AXI_ADDR_W'(8 * i + 4), vals[i][63:32], RESP_OKAY);
    end
    drive_commits(0, 40);
    repeat (2) @(posedge clk);
    #1;
    for (int i = 0; i < NUM_CNT; i++) begin
      read_counter(i, v);
      check_counter(v, vals[i], $sformatf("counter %0d written while inhibited", i));
    end
  endtask

  // Counters stay cleared where their inhibit bit is set
  task automatic count_events(input logic [NUM_HPM-1:0][7:0] codes, input int kind,
                              input logic [INH_W-1:0] enable_inh);
    logic [CNT_W-1:0] v;
    exp_by_code = '{default: 0};
    for (int h = 0; h < NUM_HPM; h++) begin
      axil_write(ADDR_EVSEL_BASE + AXI_ADDR_W'(4 * h), AXI_DATA_W'(codes[h]), RESP_OKAY);
    end
    for (int i = 0; i < 2 * NUM_CNT; i++) begin
      axil_write(ADDR_CNT_BASE + AXI_ADDR_W'(4 * i), '0, RESP_OKAY);
    end
    axil_write(ADDR_INHIBIT, AXI_DATA_W'(enable_inh), RESP_OKAY);
    drive_commits(kind, 200);
    repeat (2) @(posedge clk);
    #1;
    axil_write(ADDR_INHIBIT, ALL_INH, RESP_OKAY);
    read_counter(1, v);
    check_counter(v, enable_inh[INH_IR_BIT] ? '0 : CNT_W'(exp_by_code[EV_NEW_INST]), "minstret");
    for (int h = 0; h < NUM_HPM; h++) begin
      read_counter(2 + h, v);
      check_counter(v, enable_inh[INH_HPM_BASE + h] ? '0 : CNT_W'(exp_by_code[codes[h]]),
                    $sformatf("hpm%0d with code %0d", h + 3, codes[h]));
    end
  endtask

  task automatic mcycle_enable();
    logic [CNT_W-1:0] a;
    logic [CNT_W-1:0] b;
    axil_write(ADDR_INHIBIT, 32'h7E, RESP_OKAY);
    read_counter(0, a);
    read_counter(0, b);
    if (!(b > a)) begin
      $display("[FAIL] %0t: mcycle did not advance, %0d then %0d", $time, a, b);
      error_count++;
    end
    axil_write(ADDR_INHIBIT, ALL_INH, RESP_OKAY);
    read_counter(0, a);
    read_counter(0, b);
    check_counter(b, a, "mcycle held while inhibited");
  endtask

  initial begin
    {rst, awvalid, wvalid, bready, arvalid, rready} = '0;
    {awaddr, araddr, wdata, wstrb} = '0;
    commit = '0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b1;
    register_access();
    counter_write_inhibited();
    count_events({EV_NEW_INST, EV_NEW_INST, EV_NEW_INST, EV_NEW_INST}, 0, 7'h7B);
    count_events({EV_SC_DWORD, EV_SC_WORD, EV_BRANCH_TAKEN, EV_BRANCH}, 1, 7'h03);
    count_events({EV_VEC_DWORD, EV_VEC_WORD, EV_VEC_HWORD, EV_VEC_BYTE}, 2, 7'h03);
    // Codes outside the event table
    count_events({8'd200, 8'd11, 8'd8, 8'd3}, 2, 7'h03);
    mcycle_enable();
    $display("Errors: %0d wrong values, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+include
design/pmu_pkg.sv
design/pmu_event_decode.sv
design/pmu_counter_bank.sv
design/pmu_axil_regs.sv
design/pmu_top.sv
tests/tb_pmu_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pmu_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
JOBS      ?= 0

SRCS := $(wildcard design/*.sv tests/*.sv include/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "Test passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
